/* logic/acc_num_pkg.sv */
package acc_num_pkg;

    localparam int unsigned DATA_W     = 32; // Accumulator and result width.
    localparam int unsigned WORD_W     = 16; // Width of one input word.
    localparam int unsigned TAG_W      = 4;
    localparam int unsigned FIFO_DEPTH = 8;

    localparam int unsigned SHIFT_W = 4;
    localparam int unsigned MANT_W  = 8;
    localparam int unsigned RSVD_W  = WORD_W - SHIFT_W - MANT_W;

    typedef logic signed [WORD_W-1:0] addend_t; // Sign-extended to DATA_W when used.

    typedef struct packed {
        logic [RSVD_W-1:0]  rsvd;
        logic [SHIFT_W-1:0] shift;
        logic [MANT_W-1:0]  mant; // Factor value is mant << shift.
    } factor_t;

    // The same input word carries either an addend or a factor.
    typedef union packed {
        addend_t addend;
        factor_t factor;
    } item_word_u;

    typedef struct packed {
        logic       is_factor;
        logic       last;
        item_word_u word;
    } item_t;

    typedef struct packed {
        addend_t          value;
        logic [TAG_W-1:0] tag; // Factors accepted before this addend.
    } tagged_addend_t;

    typedef struct packed {
        factor_t          value;
        logic [TAG_W-1:0] tag;
    } tagged_factor_t;

endpackage

/* logic/acc_pipe_pkg.sv */
package acc_pipe_pkg;

    localparam int unsigned PIPE_DEPTH = 3; // MAC latency, also the number of slots.
    localparam int unsigned CNT_W      = $clog2(PIPE_DEPTH + 1);

    // Result of the MAC is mul_a * mul_b + add_c.
    typedef struct packed {
        logic                             valid;
        logic [acc_num_pkg::DATA_W-1:0]   mul_a;
        logic [acc_num_pkg::DATA_W-1:0]   mul_b;
        logic [acc_num_pkg::DATA_W-1:0]   add_c;
        logic [acc_num_pkg::TAG_W-1:0]    tag;
    } mac_req_t;

    typedef struct packed {
        logic                             valid;
        logic [acc_num_pkg::DATA_W-1:0]   value;
        logic [acc_num_pkg::TAG_W-1:0]    tag; // Factors already applied to this partial.
    } partial_t;

endpackage

/* logic/tag_fifo.sv */
`timescale 1ns/1ps

module tag_fifo #(
    parameter int unsigned DEPTH = 8,
    parameter int unsigned WIDTH = 20
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem_q[rd_ptr_q]; // Head is visible without a pop.

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push != do_pop) begin
                count_q <= do_push ? count_q + 1'b1 : count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* logic/acc_intake.sv */
`timescale 1ns/1ps

module acc_intake (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        in_valid_i,
    input  acc_num_pkg::item_t          in_item_i,
    output logic                        in_ready_o,
    output acc_num_pkg::tagged_addend_t addend_o,
    output logic                        addend_empty_o,
    input  logic                        addend_pop_i,
    output acc_num_pkg::tagged_factor_t factor_o,
    output logic                        factor_empty_o,
    input  logic                        factor_pop_i,
    output logic                        stream_closed_o,
    input  logic                        result_taken_i
);

    logic                            accept;
    logic                            addend_full;
    logic                            factor_full;
    logic [acc_num_pkg::TAG_W-1:0]   tag_q;
    logic                            closed_q;
    acc_num_pkg::tagged_addend_t     addend_in;
    acc_num_pkg::tagged_factor_t     factor_in;

    assign in_ready_o      = ~addend_full & ~factor_full & ~closed_q;
    assign accept          = in_valid_i & in_ready_o;
    assign stream_closed_o = closed_q;

    // Both views of the word are prepared and the item flag picks the FIFO.
    assign addend_in.value = in_item_i.word.addend;
    assign addend_in.tag   = tag_q;
    assign factor_in.value = in_item_i.word.factor;
    assign factor_in.tag   = tag_q; // A factor carries the count before itself.

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_q    <= '0;
            closed_q <= 1'b0;
        end else if (result_taken_i) begin
            tag_q    <= '0; // Next stream counts its factors from zero.
            closed_q <= 1'b0;
        end else if (accept) begin
            if (in_item_i.is_factor) begin
                tag_q <= tag_q + 1'b1;
            end
            if (in_item_i.last) begin
                closed_q <= 1'b1;
            end
        end
    end

    tag_fifo #(
        .DEPTH (acc_num_pkg::FIFO_DEPTH),
        .WIDTH ($bits(acc_num_pkg::tagged_addend_t))
    ) addend_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (result_taken_i),
        .push_i  (accept & ~in_item_i.is_factor),
        .data_i  (addend_in),
        .pop_i   (addend_pop_i),
        .data_o  (addend_o),
        .full_o  (addend_full),
        .empty_o (addend_empty_o)
    );

    tag_fifo #(
        .DEPTH (acc_num_pkg::FIFO_DEPTH),
        .WIDTH ($bits(acc_num_pkg::tagged_factor_t))
    ) factor_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (result_taken_i),
        .push_i  (accept & in_item_i.is_factor),
        .data_i  (factor_in),
        .pop_i   (factor_pop_i),
        .data_o  (factor_o),
        .full_o  (factor_full),
        .empty_o (factor_empty_o)
    );

endmodule

/* logic/acc_issue.sv */
`timescale 1ns/1ps

module acc_issue (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  acc_num_pkg::tagged_addend_t       addend_i,
    input  logic                              addend_empty_i,
    output logic                              addend_pop_o,
    input  acc_num_pkg::tagged_factor_t       factor_i,
    input  logic                              factor_empty_i,
    output logic                              factor_pop_o,
    input  logic                              stream_closed_i,
    input  acc_pipe_pkg::partial_t            ret_i,
    output acc_pipe_pkg::mac_req_t            req_o,
    output logic                              out_valid_o,
    input  logic                              out_ready_i,
    output logic [acc_num_pkg::DATA_W-1:0]    out_sum_o,
    output logic                              result_taken_o
);

    logic [acc_num_pkg::DATA_W-1:0]   addend_val;
    logic [acc_num_pkg::DATA_W-1:0]   factor_val;
    logic                             addend_same_tag;
    logic                             fac_hit;
    logic                             add_hit;
    logic                             start;
    logic                             retire;
    logic                             reduce;
    logic                             drop;
    logic [acc_pipe_pkg::CNT_W-1:0]   live_q;
    logic [acc_pipe_pkg::CNT_W-1:0]   pending_q;
    logic [acc_num_pkg::DATA_W-1:0]   hold_q;
    logic                             out_valid_q;

    assign addend_val = {{(acc_num_pkg::DATA_W - acc_num_pkg::WORD_W)
                          {addend_i.value[acc_num_pkg::WORD_W-1]}},
                         addend_i.value};
    assign factor_val = {{(acc_num_pkg::DATA_W - acc_num_pkg::MANT_W){1'b0}},
                         factor_i.value.mant} << factor_i.value.shift;

    // Addends of the factor's own epoch must be absorbed before that factor is applied.
    assign addend_same_tag = ~addend_empty_i & (addend_i.tag == factor_i.tag);

    assign fac_hit = ret_i.valid & ~factor_empty_i & (ret_i.tag == factor_i.tag) & ~addend_same_tag;
    assign add_hit = ret_i.valid & ~fac_hit & ~addend_empty_i & (ret_i.tag == addend_i.tag);
    assign start   = ~ret_i.valid & ~addend_empty_i & (factor_empty_i | addend_same_tag);
    assign retire  = ~factor_empty_i & (pending_q == '0) & ~addend_same_tag;
    assign reduce  = stream_closed_i & addend_empty_i & factor_empty_i & ~out_valid_q;
    assign drop    = ret_i.valid & reduce;

    assign addend_pop_o   = start | add_hit;
    assign factor_pop_o   = retire;
    assign out_valid_o    = out_valid_q;
    assign out_sum_o      = hold_q;
    assign result_taken_o = out_valid_q & out_ready_i;

    always_comb begin
        req_o.valid = start | (ret_i.valid & ~reduce);
        req_o.mul_a = ret_i.value;
        req_o.mul_b = {{(acc_num_pkg::DATA_W - 1){1'b0}}, 1'b1};
        req_o.add_c = '0;
        req_o.tag   = ret_i.tag;
        if (start) begin
            req_o.mul_a = '0; // A fresh partial is just the addend.
            req_o.mul_b = '0;
            req_o.add_c = addend_val;
            req_o.tag   = addend_i.tag;
        end else if (fac_hit) begin
            req_o.mul_b = factor_val;
            req_o.tag   = ret_i.tag + 1'b1;
        end else if (add_hit) begin
            req_o.add_c = addend_val;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            live_q    <= '0;
            pending_q <= '0;
        end else if (result_taken_o) begin
            live_q    <= '0;
            pending_q <= '0;
        end else begin
            if (start) begin
                live_q <= live_q + 1'b1;
            end else if (drop) begin
                live_q <= live_q - 1'b1;
            end
            // After a retirement every live partial waits for the next factor.
            if (retire) begin
                pending_q <= live_q;
            end else if (start) begin
                pending_q <= pending_q + 1'b1;
            end else if (fac_hit) begin
                pending_q <= pending_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q      <= '0;
            out_valid_q <= 1'b0;
        end else if (result_taken_o) begin
            hold_q      <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (drop) begin
                hold_q <= hold_q + ret_i.value; // Partials fold into the result one by one.
            end
            if (reduce && live_q == '0) begin
                out_valid_q <= 1'b1;
            end
        end
    end

endmodule

/* logic/acc_mac_pipe.sv */
`timescale 1ns/1ps

module acc_mac_pipe (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  acc_pipe_pkg::mac_req_t  req_i,
    output acc_pipe_pkg::partial_t  ret_o
);

    logic                             s1_valid_q;
    logic [acc_num_pkg::DATA_W-1:0]   s1_a_q;
    logic [acc_num_pkg::DATA_W-1:0]   s1_b_q;
    logic [acc_num_pkg::DATA_W-1:0]   s1_c_q;
    logic [acc_num_pkg::TAG_W-1:0]    s1_tag_q;
    logic                             s2_valid_q;
    logic [acc_num_pkg::DATA_W-1:0]   s2_prod_q;
    logic [acc_num_pkg::DATA_W-1:0]   s2_c_q;
    logic [acc_num_pkg::TAG_W-1:0]    s2_tag_q;
    logic                             s3_valid_q;
    logic [acc_num_pkg::DATA_W-1:0]   s3_sum_q;
    logic [acc_num_pkg::TAG_W-1:0]    s3_tag_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_i.valid;
            s2_valid_q <= s1_valid_q;
            s3_valid_q <= s2_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_a_q    <= req_i.mul_a;
        s1_b_q    <= req_i.mul_b;
        s1_c_q    <= req_i.add_c;
        s1_tag_q  <= req_i.tag;
        s2_prod_q <= s1_a_q * s1_b_q; // Low word only, modulo 2^32.
        s2_c_q    <= s1_c_q;
        s2_tag_q  <= s1_tag_q;
        s3_sum_q  <= s2_prod_q + s2_c_q;
        s3_tag_q  <= s2_tag_q;
    end

    assign ret_o.valid = s3_valid_q;
    assign ret_o.value = s3_sum_q;
    assign ret_o.tag   = s3_tag_q;

endmodule

/* logic/scaled_acc_top.sv */
`timescale 1ns/1ps

module scaled_acc_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             in_valid_i,
    input  acc_num_pkg::item_t               in_item_i,
    output logic                             in_ready_o,
    output logic                             out_valid_o,
    input  logic                             out_ready_i,
    output logic [acc_num_pkg::DATA_W-1:0]   out_sum_o
);

    acc_num_pkg::tagged_addend_t   addend;
    logic                          addend_empty;
    logic                          addend_pop;
    acc_num_pkg::tagged_factor_t   factor;
    logic                          factor_empty;
    logic                          factor_pop;
    logic                          stream_closed;
    logic                          result_taken;
    acc_pipe_pkg::mac_req_t        mac_req;
    acc_pipe_pkg::partial_t        mac_ret;

    acc_intake acc_intake_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .in_valid_i      (in_valid_i),
        .in_item_i       (in_item_i),
        .in_ready_o      (in_ready_o),
        .addend_o        (addend),
        .addend_empty_o  (addend_empty),
        .addend_pop_i    (addend_pop),
        .factor_o        (factor),
        .factor_empty_o  (factor_empty),
        .factor_pop_i    (factor_pop),
        .stream_closed_o (stream_closed),
        .result_taken_i  (result_taken)
    );

    acc_issue acc_issue_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .addend_i        (addend),
        .addend_empty_i  (addend_empty),
        .addend_pop_o    (addend_pop),
        .factor_i        (factor),
        .factor_empty_i  (factor_empty),
        .factor_pop_o    (factor_pop),
        .stream_closed_i (stream_closed),
        .ret_i           (mac_ret),
        .req_o           (mac_req),
        .out_valid_o     (out_valid_o),
        .out_ready_i     (out_ready_i),
        .out_sum_o       (out_sum_o),
        .result_taken_o  (result_taken)
    );

    acc_mac_pipe acc_mac_pipe_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (mac_req),
        .ret_o  (mac_ret)
    );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int unsigned HALF_PERIOD_NS = 20,
    parameter int unsigned RESET_CYCLES   = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS);
            clk_o = ~clk_o;
        end
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1; // Released away from the rising edge.
    end

endmodule

/* bench/scaled_acc_props.sv */
`timescale 1ns/1ps

module scaled_acc_props (
    input logic                           clk_i,
    input logic                           rst_ni,
    input logic                           in_valid_i,
    input acc_num_pkg::item_t             in_item_i,
    input logic                           in_ready_i,
    input logic                           out_valid_i,
    input logic                           out_ready_i,
    input logic [acc_num_pkg::DATA_W-1:0] out_sum_i
);

    // A result that is not taken stays valid with the same value.
    hold_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_sum_i))
        else $error("Result changed or vanished while out_ready_i was low.");

    close_stream: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_valid_i && in_ready_i && in_item_i.last |=> !in_ready_i)
        else $error("Input was still ready after the last item of a stream.");

    block_input: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i |-> !in_ready_i)
        else $error("Input was ready while a result was waiting.");

    reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |-> in_ready_i && !out_valid_i)
        else $error("Wrong handshake state right after reset.");

endmodule

/* bench/scaled_acc_tb.sv */
`timescale 1ns/1ps

module scaled_acc_tb;

    typedef struct packed {
        logic        is_factor;
        logic        last;
        logic [15:0] word;
        logic        stall;    // Random idle cycles and output stalls for this item.
        logic [31:0] expected; // Used on the last row of a stream.
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    acc_num_pkg::item_t  in_item;
    logic                in_ready;
    logic                out_valid;
    logic                out_ready;
    logic [31:0]         out_sum;

    row_t        rows[$];
    string       names[$];
    logic [31:0] exp_q[$];
    string       exp_name_q[$];
    logic        table_built;
    logic        stall_mode;
    logic        hold_seen;
    logic [31:0] held_sum;
    logic        blocked_mid_stream;

    clk_gen clk_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    scaled_acc_top scaled_acc_top_i (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .in_valid_i  (in_valid),
        .in_item_i   (in_item),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_sum_o   (out_sum)
    );

    bind scaled_acc_top scaled_acc_props props_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_item_i   (in_item_i),
        .in_ready_i  (in_ready_o),
        .out_valid_i (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_sum_i   (out_sum_o)
    );

    task automatic stop_run(input string msg);
        $display("%0s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("CHECK FAILED %0s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    function automatic void add_row(input logic is_factor, input logic last,
                                    input logic [15:0] word, input logic stall,
                                    input logic [31:0] expected, input string name);
        rows.push_back({is_factor, last, word, stall, expected});
        names.push_back(name);
    endfunction

    // Factor words are {rsvd, shift, mant}, so 16'h0205 scales by 5 << 2.
    function automatic void build_table();
        add_row(1'b0, 1'b0, 16'h0064, 1'b0, 32'h0, "plain_sum");
        add_row(1'b0, 1'b0, 16'hfffb, 1'b0, 32'h0, "plain_sum");
        add_row(1'b0, 1'b0, 16'h0007, 1'b0, 32'h0, "plain_sum");
        add_row(1'b0, 1'b1, 16'hff38, 1'b0, 32'hffffff9e, "plain_sum");
        add_row(1'b0, 1'b0, 16'h0003, 1'b1, 32'h0, "interleave");
        add_row(1'b1, 1'b0, 16'h0101, 1'b1, 32'h0, "interleave");
        add_row(1'b0, 1'b0, 16'h0004, 1'b1, 32'h0, "interleave");
        add_row(1'b1, 1'b0, 16'h0205, 1'b1, 32'h0, "interleave");
        add_row(1'b0, 1'b1, 16'hffff, 1'b1, 32'h000000c7, "interleave");
        add_row(1'b1, 1'b0, 16'h0003, 1'b1, 32'h0, "lead_factor");
        add_row(1'b0, 1'b0, 16'h0005, 1'b1, 32'h0, "lead_factor");
        add_row(1'b0, 1'b1, 16'h0006, 1'b1, 32'h0000000b, "lead_factor");
        add_row(1'b0, 1'b0, 16'h0007, 1'b0, 32'h0, "consec_factor");
        add_row(1'b1, 1'b0, 16'h0003, 1'b0, 32'h0, "consec_factor");
        add_row(1'b1, 1'b0, 16'h0203, 1'b0, 32'h0, "consec_factor");
        add_row(1'b0, 1'b1, 16'h0002, 1'b0, 32'h000000fe, "consec_factor");
        add_row(1'b0, 1'b0, 16'hffe2, 1'b1, 32'h0, "last_factor");
        add_row(1'b0, 1'b0, 16'h000a, 1'b1, 32'h0, "last_factor");
        add_row(1'b1, 1'b1, 16'h0205, 1'b1, 32'hfffffe70, "last_factor");
        add_row(1'b1, 1'b1, 16'h0003, 1'b1, 32'h0, "factor_only");
        add_row(1'b0, 1'b0, 16'h7fff, 1'b1, 32'h0, "out_stall");
        add_row(1'b1, 1'b0, 16'h0801, 1'b1, 32'h0, "out_stall");
        add_row(1'b0, 1'b0, 16'h7fff, 1'b1, 32'h0, "out_stall");
        add_row(1'b1, 1'b1, 16'h0801, 1'b1, 32'h807eff00, "out_stall");
        // Fourteen factors in a row outrun the MAC and fill the factor FIFO.
        for (int k = 1; k <= 3; k++) begin
            add_row(1'b0, 1'b0, 16'(k), 1'b0, 32'h0, "burst");
        end
        for (int k = 0; k < 14; k++) begin
            add_row(1'b1, 1'b0, 16'h0002, 1'b0, 32'h0, "burst");
        end
        for (int k = 1; k <= 4; k++) begin
            add_row(1'b0, k == 4, 16'(10 * k), 1'b0, (k == 4) ? 32'h00018064 : 32'h0, "burst");
        end
    endfunction

    function automatic logic [31:0] stream_sum(input int first_idx, input int last_idx);
        logic [31:0] prod;
        logic [31:0] sum;
        prod = 32'd1;
        sum  = 32'd0;
        for (int k = last_idx; k >= first_idx; k--) begin
            if (rows[k].is_factor) begin
                prod = prod * (32'(rows[k].word[7:0]) << rows[k].word[11:8]);
            end else begin
                sum = sum + {{16{rows[k].word[15]}}, rows[k].word} * prod;
            end
        end
        return sum;
    endfunction

    // One clock of the output side, sampled at the falling edge.
    task automatic next_cycle();
        @(negedge clk);
        if (hold_seen) begin
            check_value("held_valid", 32'h1, 32'(out_valid));
            check_value("held_sum", held_sum, out_sum);
        end
        out_ready = stall_mode ? 1'($urandom_range(1)) : 1'b1;
        hold_seen = out_valid && !out_ready;
        held_sum  = out_sum;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                stop_run("A result appeared although no stream was waiting for one.");
            end
            check_value(exp_name_q.pop_front(), exp_q.pop_front(), out_sum);
        end
    endtask

    initial begin
        int          stream_start;
        logic [31:0] model;
        void'($urandom(32'hda1d));
        in_valid           = 1'b0;
        in_item            = '0;
        out_ready          = 1'b0;
        stall_mode         = 1'b0;
        hold_seen          = 1'b0;
        held_sum           = '0;
        blocked_mid_stream = 1'b0;
        table_built        = 1'b0;
        build_table();
        table_built = 1'b1;
        wait (rst_n === 1'b1);
        next_cycle();
        check_value("reset_in_ready", 32'h1, 32'(in_ready));
        check_value("reset_out_valid", 32'h0, 32'(out_valid));
        stream_start = 0;
        for (int i = 0; i < rows.size(); i++) begin
            stall_mode = rows[i].stall;
            in_valid   = 1'b0;
            if (rows[i].stall) begin
                repeat ($urandom_range(2)) next_cycle();
            end
            if (rows[i].last) begin
                model = stream_sum(stream_start, i);
                check_value({names[i], "_model"}, rows[i].expected, model);
                exp_q.push_back(model);
                exp_name_q.push_back(names[i]);
            end
            in_valid = 1'b1;
            in_item  = {rows[i].is_factor, rows[i].last, rows[i].word};
            while (!in_ready) begin
                if (i != stream_start) begin
                    blocked_mid_stream = 1'b1; // Only a full FIFO blocks inside a stream.
                end
                next_cycle();
            end
            next_cycle();
            if (rows[i].last) begin
                stream_start = i + 1;
            end
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        next_cycle(); // A repeated result would arrive here with no stream waiting for it.
        check_value("fifo_full_seen", 32'h1, 32'(blocked_mid_stream));
        $display("STATUS: PASS");
        $finish;
    end

    // Forty clocks of 40 ns for every row of the table.
    initial begin
        wait (table_built === 1'b1);
        #(64'(rows.size()) * 64'd1600);
        stop_run("Watchdog expired before all stream results were received.");
    end

endmodule

/* scaled_acc.f */
logic/acc_num_pkg.sv
logic/acc_pipe_pkg.sv
logic/tag_fifo.sv
logic/acc_intake.sv
logic/acc_issue.sv
logic/acc_mac_pipe.sv
logic/scaled_acc_top.sv
bench/clk_gen.sv
bench/scaled_acc_props.sv
bench/scaled_acc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module scaled_acc_tb -f scaled_acc.f -o scaled_acc_sim

output=$(./obj_dir/scaled_acc_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
